//--- files.f
hdl/cache_pkg.sv
hdl/mem_arbiter.sv
hdl/icache.sv
hdl/dcache.sv
hdl/mem_subsystem.sv
testbench/burst_mem_model.sv
testbench/tb_mem_subsystem.sv

//--- hdl/cache_pkg.sv
package cache_pkg;

	localparam int OFFSET_BITS    = 5;   // 32 bytes per line
	localparam int INDEX_BITS     = 3;
	localparam int NUM_SETS       = 8;
	localparam int BEATS_PER_LINE = 4;   // 64-bit beats on the memory port
	localparam int WORDS_PER_LINE = 8;

	typedef logic [31:0]  addr_t;
	typedef logic [31:0]  word_t;
	typedef logic [63:0]  beat_t;
	typedef logic [255:0] line_t;
	typedef logic [$bits(addr_t)-OFFSET_BITS-INDEX_BITS-1:0] tag_t;
	typedef logic [INDEX_BITS-1:0] index_t;

	// a cache asks for one whole line and the address is always line aligned
	typedef struct packed {
		addr_t addr;
		logic  read;
		logic  write;
	} line_req_t;

	typedef struct packed {
		addr_t addr;
		logic  read;
		logic  write;
		beat_t wdata;
	} mem_cmd_t;

	typedef enum logic [1:0] {IDLE, READ_BEAT, WRITE_BEAT, DONE} arb_state_t;

	// the instruction cache never enters WRITEBACK
	typedef enum logic [1:0] {LOOKUP, WRITEBACK, FILL, RESPOND} cache_state_t;

endpackage

//--- hdl/dcache.sv
module dcache import cache_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,

	input  addr_t     d_addr_i,
	input  logic      d_read_i,
	input  logic      d_write_i,
	input  word_t     d_wdata_i,
	output word_t     d_rdata_o,
	output logic      d_resp_o,

	output line_req_t req_o,
	output line_t     wline_o,
	input  line_t     line_i,
	input  logic      resp_i
);

	cache_state_t state;
	tag_t  tag_mem  [NUM_SETS];
	line_t data_mem [NUM_SETS];
	logic [NUM_SETS-1:0] valid;
	logic [NUM_SETS-1:0] dirty;

	index_t index;
	tag_t   tag;
	logic [$clog2(WORDS_PER_LINE)-1:0] word_sel;
	logic   hit;
	line_t  base_line;
	line_t  merged_line;

	assign index    = d_addr_i[OFFSET_BITS +: INDEX_BITS];
	assign tag      = d_addr_i[$bits(addr_t)-1 -: $bits(tag_t)];
	assign word_sel = d_addr_i[OFFSET_BITS-1 -: $clog2(WORDS_PER_LINE)];
	assign hit      = valid[index] && (tag_mem[index] == tag);

	// a write lands on the stored line on a hit, or on the incoming line during a fill
	always_comb begin
		base_line   = (state == FILL) ? line_i : data_mem[index];
		merged_line = base_line;
		merged_line[word_sel*$bits(word_t) +: $bits(word_t)] = d_wdata_i;
	end

	always_ff @(posedge clk, posedge reset_n) begin
		if (reset_n) begin
			state <= LOOKUP;
			valid <= '0;
			dirty <= '0;
		end else begin
			case (state)
				LOOKUP: begin
					if (d_read_i || d_write_i) begin
						if (hit) begin
							if (d_write_i)
								dirty[index] <= 1'b1;
							state <= RESPOND;
						end else if (valid[index] && dirty[index]) begin
							state <= WRITEBACK;   // victim goes out before the fill
						end else begin
							state <= FILL;
						end
					end
				end
				WRITEBACK: begin
					if (resp_i) begin
						dirty[index] <= 1'b0;
						state        <= FILL;
					end
				end
				FILL: begin
					if (resp_i) begin
						valid[index] <= 1'b1;
						dirty[index] <= d_write_i;
						state        <= RESPOND;
					end
				end
				default: begin
					state <= LOOKUP;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == LOOKUP && hit && d_write_i) begin
			data_mem[index] <= merged_line;
		end else if (state == FILL && resp_i) begin
			tag_mem[index]  <= tag;
			data_mem[index] <= d_write_i ? merged_line : line_i;
		end
	end

	assign req_o.addr  = (state == WRITEBACK) ?
		{tag_mem[index], index, {OFFSET_BITS{1'b0}}} :
		{d_addr_i[$bits(addr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	assign req_o.read  = (state == FILL);
	assign req_o.write = (state == WRITEBACK);
	assign wline_o     = data_mem[index];

	assign d_resp_o  = (state == RESPOND);
	assign d_rdata_o = data_mem[index][word_sel*$bits(word_t) +: $bits(word_t)];

endmodule

//--- hdl/icache.sv
module icache import cache_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,

	input  addr_t     i_addr_i,
	input  logic      i_read_i,
	output word_t     i_rdata_o,
	output logic      i_resp_o,

	output line_req_t req_o,
	input  line_t     line_i,
	input  logic      resp_i
);

	cache_state_t state;
	tag_t  tag_mem  [NUM_SETS];
	line_t data_mem [NUM_SETS];
	logic [NUM_SETS-1:0] valid;

	index_t index;
	tag_t   tag;
	logic [$clog2(WORDS_PER_LINE)-1:0] word_sel;
	logic   hit;

	assign index    = i_addr_i[OFFSET_BITS +: INDEX_BITS];
	assign tag      = i_addr_i[$bits(addr_t)-1 -: $bits(tag_t)];
	assign word_sel = i_addr_i[OFFSET_BITS-1 -: $clog2(WORDS_PER_LINE)];
	assign hit      = valid[index] && (tag_mem[index] == tag);

	always_ff @(posedge clk, posedge reset_n) begin
		if (reset_n) begin
			state <= LOOKUP;
			valid <= '0;
		end else begin
			case (state)
				LOOKUP: begin
					if (i_read_i)
						state <= hit ? RESPOND : FILL;
				end
				FILL: begin
					if (resp_i) begin
						valid[index] <= 1'b1;
						state        <= RESPOND;
					end
				end
				default: begin
					state <= LOOKUP;   // RESPOND lasts one cycle
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FILL && resp_i) begin
			tag_mem[index]  <= tag;
			data_mem[index] <= line_i;
		end
	end

	assign req_o.addr  = {i_addr_i[$bits(addr_t)-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	assign req_o.read  = (state == FILL);
	assign req_o.write = 1'b0;

	assign i_resp_o  = (state == RESPOND);
	assign i_rdata_o = data_mem[index][word_sel*$bits(word_t) +: $bits(word_t)];

endmodule

//--- hdl/mem_arbiter.sv
module mem_arbiter import cache_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,

	input  line_req_t i_req_i,
	input  line_req_t d_req_i,
	input  line_t     d_wline_i,
	output line_t     line_o,
	output logic      i_resp_o,
	output logic      d_resp_o,

	output mem_cmd_t  mem_cmd_o,
	input  logic      mem_resp_i,
	input  beat_t     mem_rdata_i,

	output logic      stall_o
);

	arb_state_t state;
	logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt;
	logic  data_client;   // high when the burst in flight belongs to the data cache
	addr_t burst_addr;
	line_t line_q;
	logic  any_req;
	logic  last_beat;

	assign any_req   = d_req_i.write | d_req_i.read | i_req_i.read;
	assign last_beat = mem_resp_i && (beat_cnt == BEATS_PER_LINE - 1);

	always_ff @(posedge clk, posedge reset_n) begin
		if (reset_n) begin
			state       <= IDLE;
			beat_cnt    <= '0;
			data_client <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					beat_cnt <= '0;
					// a data write wins over a data read, which wins over an instruction read
					if (d_req_i.write) begin
						state       <= WRITE_BEAT;
						data_client <= 1'b1;
					end else if (d_req_i.read) begin
						state       <= READ_BEAT;
						data_client <= 1'b1;
					end else if (i_req_i.read) begin
						state       <= READ_BEAT;
						data_client <= 1'b0;
					end
				end
				READ_BEAT, WRITE_BEAT: begin
					if (mem_resp_i)
						beat_cnt <= beat_cnt + 1'b1;   // wraps to zero after the last beat
					if (last_beat)
						state <= DONE;
				end
				DONE: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// the address is taken once in IDLE so it cannot move during the burst
	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			if (d_req_i.write || d_req_i.read)
				burst_addr <= d_req_i.addr;
			else
				burst_addr <= i_req_i.addr;
		end
		if (state == READ_BEAT && mem_resp_i)
			line_q[beat_cnt*$bits(beat_t) +: $bits(beat_t)] <= mem_rdata_i;
	end

	always_comb begin
		mem_cmd_o.addr  = burst_addr;
		mem_cmd_o.read  = (state == READ_BEAT);
		mem_cmd_o.write = (state == WRITE_BEAT);
		mem_cmd_o.wdata = d_wline_i[beat_cnt*$bits(beat_t) +: $bits(beat_t)];   // low beat first
	end

	assign line_o   = line_q;
	assign i_resp_o = (state == DONE) && !data_client;
	assign d_resp_o = (state == DONE) && data_client;

	// a request waiting in IDLE already stalls the CPU
	assign stall_o  = (state != IDLE) || any_req;

endmodule

//--- hdl/mem_subsystem.sv
module mem_subsystem import cache_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,

	input  addr_t    i_addr_i,
	input  logic     i_read_i,
	output word_t    i_rdata_o,
	output logic     i_resp_o,

	input  addr_t    d_addr_i,
	input  logic     d_read_i,
	input  logic     d_write_i,
	input  word_t    d_wdata_i,
	output word_t    d_rdata_o,
	output logic     d_resp_o,

	output mem_cmd_t mem_cmd_o,
	input  logic     mem_resp_i,
	input  beat_t    mem_rdata_i,

	output logic     stall_o
);

	line_req_t i_req;
	line_req_t d_req;
	line_t     d_wline;
	line_t     arb_line;   // one fill bus shared by both caches
	logic      i_arb_resp;
	logic      d_arb_resp;

	icache u_icache (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_addr_i  (i_addr_i),
		.i_read_i  (i_read_i),
		.i_rdata_o (i_rdata_o),
		.i_resp_o  (i_resp_o),
		.req_o     (i_req),
		.line_i    (arb_line),
		.resp_i    (i_arb_resp)
	);

	dcache u_dcache (
		.clk       (clk),
		.reset_n   (reset_n),
		.d_addr_i  (d_addr_i),
		.d_read_i  (d_read_i),
		.d_write_i (d_write_i),
		.d_wdata_i (d_wdata_i),
		.d_rdata_o (d_rdata_o),
		.d_resp_o  (d_resp_o),
		.req_o     (d_req),
		.wline_o   (d_wline),
		.line_i    (arb_line),
		.resp_i    (d_arb_resp)
	);

	mem_arbiter u_arbiter (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_req_i     (i_req),
		.d_req_i     (d_req),
		.d_wline_i   (d_wline),
		.line_o      (arb_line),
		.i_resp_o    (i_arb_resp),
		.d_resp_o    (d_arb_resp),
		.mem_cmd_o   (mem_cmd_o),
		.mem_resp_i  (mem_resp_i),
		.mem_rdata_i (mem_rdata_i),
		.stall_o     (stall_o)
	);

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module tb_mem_subsystem -f files.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || grep -q "All tests passed" sim.log

//--- testbench/burst_mem_model.sv
module burst_mem_model import cache_pkg::*; (
	input  logic     clk,
	input  mem_cmd_t cmd_i,
	output logic     resp_o,
	output beat_t    rdata_o
);

	timeunit 1ns;
	timeprecision 100ps;

	word_t  stored [addr_t];   // only the words that a write burst has touched
	integer seed = 15729;
	int     beat;
	int     delay_left;
	addr_t  beat_addr;

	// every word starts out as its own byte address plus A5000000
	function automatic word_t peek_word(addr_t addr);
		addr_t word_addr;
		word_addr = {addr[31:2], 2'b00};
		if (stored.exists(word_addr))
			return stored[word_addr];
		return word_addr + 32'hA500_0000;
	endfunction

	initial begin
		resp_o     = 1'b0;
		rdata_o    = '0;
		beat       = 0;
		delay_left = -1;
		forever begin
			@(posedge clk);
			#1;
			if (resp_o) begin
				resp_o     = 1'b0;   // the arbiter took this beat on the edge
				beat       = (beat + 1) % BEATS_PER_LINE;
				delay_left = -1;
			end
			if (cmd_i.read || cmd_i.write) begin
				if (delay_left < 0)
					delay_left = $unsigned($random(seed)) % 4;
				if (delay_left == 0) begin
					beat_addr = cmd_i.addr + beat * 8;
					if (cmd_i.write) begin
						stored[beat_addr]     = cmd_i.wdata[31:0];
						stored[beat_addr + 4] = cmd_i.wdata[63:32];
					end else begin
						rdata_o = {peek_word(beat_addr + 4), peek_word(beat_addr)};
					end
					resp_o = 1'b1;
				end else begin
					delay_left = delay_left - 1;
				end
			end
		end
	end

endmodule

//--- testbench/tb_mem_subsystem.sv
module tb_mem_subsystem import cache_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int    TIMEOUT_CYCLES = 200;
	localparam addr_t CODE_OFFSET    = 32'h0001_0000;   // fetches sit above every data address

	typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_MEMCHK} op_t;

	typedef struct packed {
		logic  port_d;   // 0 for the instruction port, 1 for the data port
		op_t   op;
		addr_t addr;
		word_t wdata;
		logic  fetch;    // a data access also fetches from addr plus CODE_OFFSET
	} stim_t;

	logic     clk;
	logic     reset_n;
	addr_t    i_addr;
	logic     i_read;
	word_t    i_rdata;
	logic     i_resp;
	addr_t    d_addr;
	logic     d_read;
	logic     d_write;
	word_t    d_wdata;
	word_t    d_rdata;
	logic     d_resp;
	mem_cmd_t mem_cmd;
	logic     mem_resp;
	beat_t    mem_rdata;
	logic     stall;

	stim_t stim_table [$];
	word_t shadow [addr_t];   // words written by the CPU, as the CPU should see them
	addr_t i_ref_line [NUM_SETS];   // line address that each set should hold
	addr_t d_ref_line [NUM_SETS];
	logic [NUM_SETS-1:0] i_ref_valid = '0;
	logic [NUM_SETS-1:0] d_ref_valid = '0;
	int    check_count    = 0;
	int    mismatch_count = 0;
	int    other_errors   = 0;
	int    burst_cycles   = 0;
	logic  run_ok;

	mem_subsystem uut (
		.clk(clk), .reset_n(reset_n),
		.i_addr_i(i_addr), .i_read_i(i_read), .i_rdata_o(i_rdata), .i_resp_o(i_resp),
		.d_addr_i(d_addr), .d_read_i(d_read), .d_write_i(d_write), .d_wdata_i(d_wdata),
		.d_rdata_o(d_rdata), .d_resp_o(d_resp),
		.mem_cmd_o(mem_cmd), .mem_resp_i(mem_resp), .mem_rdata_i(mem_rdata),
		.stall_o(stall)
	);

	burst_mem_model mem_model (
		.clk(clk), .cmd_i(mem_cmd), .resp_o(mem_resp), .rdata_o(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic word_t shadow_word(addr_t addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return addr + 32'hA500_0000;   // untouched words keep the initial memory pattern
	endfunction

	// a direct-mapped set keeps the last line that was brought into it
	function automatic logic predict_hit(logic port_d, addr_t addr);
		addr_t line_addr;
		int    set_idx;
		logic  hit;
		line_addr = addr >> OFFSET_BITS;
		set_idx   = line_addr % NUM_SETS;
		if (port_d) begin
			hit                  = d_ref_valid[set_idx] && (d_ref_line[set_idx] == line_addr);
			d_ref_valid[set_idx] = 1'b1;
			d_ref_line[set_idx]  = line_addr;
		end else begin
			hit                  = i_ref_valid[set_idx] && (i_ref_line[set_idx] == line_addr);
			i_ref_valid[set_idx] = 1'b1;
			i_ref_line[set_idx]  = line_addr;
		end
		return hit;
	endfunction

	task automatic check_word(word_t actual, word_t expected, string what);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s gave %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_flag(logic actual, logic expected, string what);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic add_stim(logic port_d, op_t op, addr_t addr, word_t wdata, logic fetch);
		stim_table.push_back('{port_d, op, addr, wdata, fetch});
	endtask

	// a port drops its request on the edge after its resp cycle
	task automatic wait_responses(input logic want_i, input logic want_d,
		output word_t i_word, output word_t d_word, output int i_cycles,
		output int d_cycles, output logic ok);
		logic i_pending;
		logic d_pending;
		int   cycles;
		i_pending = want_i;
		d_pending = want_d;
		cycles    = 0;
		ok        = 1'b1;
		i_word    = '0;
		d_word    = '0;
		i_cycles  = 0;
		d_cycles  = 0;
		while ((i_pending || d_pending) && ok) begin
			@(negedge clk);
			if (i_pending && i_resp) begin
				i_word    = i_rdata;
				i_cycles  = cycles;
				i_pending = 1'b0;
			end
			if (d_pending && d_resp) begin
				d_word    = d_rdata;
				d_cycles  = cycles;
				d_pending = 1'b0;
			end
			@(posedge clk);
			#1;
			if (!i_pending)
				i_read = 1'b0;
			if (!d_pending) begin
				d_read  = 1'b0;
				d_write = 1'b0;
			end
			cycles++;
			if ((i_pending || d_pending) && cycles >= TIMEOUT_CYCLES) begin
				ok = 1'b0;
				other_errors++;
				$display("No response from the cache within %0d cycles at %0t ns",
					TIMEOUT_CYCLES, $time);
			end
		end
	endtask

	task automatic apply_entry(input stim_t s, output logic ok);
		word_t i_word;
		word_t d_word;
		addr_t fetch_addr;
		logic  want_i;
		logic  want_d;
		logic  i_hit;
		logic  d_hit;
		int    i_cycles;
		int    d_cycles;
		ok = 1'b1;
		if (s.op == OP_MEMCHK) begin
			check_word(mem_model.peek_word(s.addr), shadow_word(s.addr),
				$sformatf("memory copy at %h", s.addr));
			return;
		end
		want_d     = s.port_d;
		want_i     = !s.port_d || s.fetch;
		fetch_addr = s.port_d ? s.addr + CODE_OFFSET : s.addr;
		i_hit      = 1'b0;
		d_hit      = 1'b0;
		if (want_i) begin
			i_hit  = predict_hit(1'b0, fetch_addr);
			i_addr = fetch_addr;
			i_read = 1'b1;
		end
		if (want_d) begin
			d_hit   = predict_hit(1'b1, s.addr);
			d_addr  = s.addr;
			d_wdata = s.wdata;
			d_read  = (s.op == OP_READ);
			d_write = (s.op == OP_WRITE);
		end
		wait_responses(want_i, want_d, i_word, d_word, i_cycles, d_cycles, ok);
		if (!ok)
			return;
		if (want_i) begin
			check_word(i_word, shadow_word(fetch_addr), $sformatf("fetch at %h", fetch_addr));
			check_flag(i_cycles == 1, i_hit,
				$sformatf("one-cycle hit of fetch at %h", fetch_addr));
		end
		if (want_d && s.op == OP_WRITE) begin
			shadow[s.addr] = s.wdata;
		end else if (want_d) begin
			check_word(d_word, shadow_word(s.addr), $sformatf("data read at %h", s.addr));
			check_flag(d_cycles == 1, d_hit,
				$sformatf("one-cycle hit of data read at %h", s.addr));
		end
	endtask

	always @(negedge clk) begin
		if (mem_cmd.read || mem_cmd.write) begin
			burst_cycles++;
			check_flag(stall, 1'b1, "stall_o during a burst");
		end
	end

	initial begin
		reset_n = 1'b1;
		i_addr  = '0;
		i_read  = 1'b0;
		d_addr  = '0;
		d_read  = 1'b0;
		d_write = 1'b0;
		d_wdata = '0;
		run_ok  = 1'b1;

		add_stim(0, OP_READ,   32'h0000_1000, 32'h0, 0);   // instruction miss followed by hits
		add_stim(0, OP_READ,   32'h0000_1004, 32'h0, 0);
		add_stim(0, OP_READ,   32'h0000_101C, 32'h0, 0);
		add_stim(0, OP_READ,   32'h0000_1100, 32'h0, 0);
		add_stim(0, OP_READ,   32'h0000_1000, 32'h0, 0);
		add_stim(1, OP_WRITE,  32'h0000_2024, 32'hDEAD_BEEF, 0);
		add_stim(1, OP_READ,   32'h0000_2024, 32'h0, 0);
		add_stim(1, OP_READ,   32'h0000_2030, 32'h0, 0);
		add_stim(1, OP_WRITE,  32'h0000_2028, 32'h1234_5678, 0);
		add_stim(1, OP_READ,   32'h0000_2028, 32'h0, 0);
		add_stim(1, OP_READ,   32'h0000_3024, 32'h0, 0);   // the same set so the dirty line goes out
		add_stim(1, OP_MEMCHK, 32'h0000_2024, 32'h0, 0);
		add_stim(1, OP_MEMCHK, 32'h0000_2028, 32'h0, 0);
		add_stim(1, OP_MEMCHK, 32'h0000_2030, 32'h0, 0);
		add_stim(1, OP_READ,   32'h0000_2024, 32'h0, 0);
		add_stim(1, OP_READ,   32'h0000_5040, 32'h0, 1);
		add_stim(1, OP_WRITE,  32'h0000_6044, 32'hCAFE_F00D, 1);
		add_stim(1, OP_READ,   32'h0000_6044, 32'h0, 1);
		add_stim(1, OP_READ,   32'h0000_7048, 32'h0, 1);
		add_stim(1, OP_MEMCHK, 32'h0000_6044, 32'h0, 0);
		add_stim(1, OP_READ,   32'h0000_6044, 32'h0, 0);

		repeat (8) @(posedge clk);
		#1;
		reset_n = 1'b0;

		repeat (4) begin
			@(negedge clk);
			check_flag(stall, 1'b0, "stall_o while idle");
			check_flag(i_resp, 1'b0, "i_resp_o while idle");
			check_flag(d_resp, 1'b0, "d_resp_o while idle");
			check_flag(mem_cmd.read, 1'b0, "memory read while idle");
			check_flag(mem_cmd.write, 1'b0, "memory write while idle");
		end
		@(posedge clk);
		#1;

		for (int n = 0; n < stim_table.size() && run_ok; n++)
			apply_entry(stim_table[n], run_ok);

		if (burst_cycles == 0) begin
			other_errors++;
			$display("No memory burst was seen during the run");
		end
		$display("Checks: %0d, mismatches: %0d, other errors: %0d",
			check_count, mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
